/* include/swo_trace_config.svh */
`ifndef SWO_TRACE_CONFIG_SVH
`define SWO_TRACE_CONFIG_SVH

// serial receiver
`define SWO_DIV_WIDTH      16

// matcher and trigger
`define MATCH_RULES        4
`define MATCH_BYTES        4
`define TRIG_COUNT_WIDTH   4
`define TRIG_PULSE_LEN     4
`define SEQ_WIDTH          16

`define STREAM_FIFO_DEPTH  8

// config port
`define CFG_ADDR_WIDTH     4
`define CFG_DATA_WIDTH     32

`define REG_BIT_DIV        4'd0
`define REG_RULE_EN        4'd1   // [3:0] rule enables, [7:4] trigger enables
`define REG_NUM_TRIG       4'd2
`define REG_CONTROL        4'd3   // [0] arm, [1] clear errors
`define REG_PATTERN0       4'd4   // patterns at 4..7
`define REG_MASK0          4'd8   // masks at 8..11

`endif

/* src/swo_trace_pkg.sv */
`default_nettype none

`include "swo_trace_config.svh"

package swo_trace_pkg;

  // one byte off the serial line
  typedef logic [7:0] swo_byte_t;

  // last MATCH_BYTES bytes, newest in bits 7:0
  typedef logic [8*`MATCH_BYTES-1:0] match_window_t;

  typedef logic [`MATCH_RULES-1:0] rule_vec_t;  // one bit per rule

  typedef logic [`TRIG_COUNT_WIDTH-1:0] trig_count_t;

  // hits in the upper bits, byte index below
  typedef struct packed {
    rule_vec_t              hits;
    logic [`SEQ_WIDTH-1:0]  seq;
  } match_event_t;

endpackage

`default_nettype wire

/* src/swo_bit_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "swo_trace_config.svh"

module swo_bit_timer (
  input  logic                      trigger_clk,
  input  logic                      reset,
  input  logic                      restart,
  input  logic [`SWO_DIV_WIDTH-1:0] bit_div,
  output logic                      tick
);

  logic [`SWO_DIV_WIDTH-1:0] cnt;
  logic [`SWO_DIV_WIDTH:0]   period;  // bit_div+1, one bit wider so it never wraps

  assign period = {1'b0, bit_div} + 1'b1;
  assign tick   = (cnt == '0);

  always_ff @(posedge trigger_clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (restart) begin
      cnt <= period[`SWO_DIV_WIDTH:1] - 1'b1;  // half a bit to the middle of start
    end else if (tick) begin
      cnt <= bit_div;  // full bit period from here on
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/swo_rx_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module swo_rx_fsm
  import swo_trace_pkg::*;
(
  input  logic      trigger_clk,
  input  logic      reset,
  input  logic      swo,
  input  logic      tick,
  output logic      restart,
  output swo_byte_t rx_byte,
  output logic      rx_valid,
  output logic      rx_frame_err
);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } rx_state_t;

  rx_state_t  state;
  logic [2:0] bit_cnt;
  logic       swo_q;  // previous line level for edge detect

  // falling edge while idle starts a frame
  // after a bad stop bit the line has to go high again first
  assign restart = (state == st_idle) && swo_q && !swo;

  always_ff @(posedge trigger_clk) begin
    if (reset) begin
      state        <= st_idle;
      bit_cnt      <= '0;
      swo_q        <= 1'b1;
      rx_valid     <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      swo_q        <= swo;
      rx_valid     <= 1'b0;
      rx_frame_err <= 1'b0;
      case (state)
        st_idle: begin
          if (restart) state <= st_start;
        end
        st_start: begin
          if (tick) begin
            if (swo) begin
              state <= st_idle;  // glitch, not a real start bit
            end else begin
              state   <= st_data;
              bit_cnt <= '0;
            end
          end
        end
        st_data: begin
          if (tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= st_stop;
          end
        end
        st_stop: begin
          if (tick) begin
            rx_valid     <= swo;
            rx_frame_err <= !swo;  // byte is dropped
            state        <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // lsb arrives first, so shift in from the top
  always_ff @(posedge trigger_clk) begin
    if (state == st_data && tick) rx_byte <= {swo, rx_byte[7:1]};
  end

endmodule

`default_nettype wire

/* src/match_rule_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "swo_trace_config.svh"

module match_rule_regs
  import swo_trace_pkg::*;
(
  input  logic                                   trigger_clk,
  input  logic                                   reset,
  input  logic                                   cfg_write,
  input  logic [`CFG_ADDR_WIDTH-1:0]             cfg_addr,
  input  logic [`CFG_DATA_WIDTH-1:0]             cfg_data,
  output logic [`SWO_DIV_WIDTH-1:0]              bit_div,
  output rule_vec_t                              rule_en,
  output rule_vec_t                              trig_en,
  output trig_count_t                            num_triggers,
  output match_window_t [`MATCH_RULES-1:0]       patterns,
  output match_window_t [`MATCH_RULES-1:0]       masks,
  output logic                                   arm,
  output logic                                   clear_errors
);

  always_ff @(posedge trigger_clk) begin
    if (reset) begin
      bit_div      <= '0;
      rule_en      <= '0;
      trig_en      <= '0;
      num_triggers <= '0;
      patterns     <= '0;
      masks        <= '0;
      arm          <= 1'b0;
      clear_errors <= 1'b0;
    end else begin
      arm          <= 1'b0;  // control bits are single-cycle strobes
      clear_errors <= 1'b0;
      if (cfg_write) begin
        case (cfg_addr)
          `REG_BIT_DIV:  bit_div <= cfg_data[`SWO_DIV_WIDTH-1:0];
          `REG_RULE_EN: begin
            rule_en <= cfg_data[`MATCH_RULES-1:0];
            trig_en <= cfg_data[2*`MATCH_RULES-1:`MATCH_RULES];
          end
          `REG_NUM_TRIG: num_triggers <= cfg_data[`TRIG_COUNT_WIDTH-1:0];
          `REG_CONTROL: begin
            arm          <= cfg_data[0];
            clear_errors <= cfg_data[1];
          end
          default: ;  // pattern/mask banks below, others ignored
        endcase
        for (int r = 0; r < `MATCH_RULES; r++) begin
          if (cfg_addr == `CFG_ADDR_WIDTH'(`REG_PATTERN0 + r)) patterns[r] <= cfg_data;
          if (cfg_addr == `CFG_ADDR_WIDTH'(`REG_MASK0 + r)) masks[r] <= cfg_data;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/trace_match_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "swo_trace_config.svh"

module trace_match_unit
  import swo_trace_pkg::*;
(
  input  logic                             trigger_clk,
  input  logic                             reset,
  input  logic                             arm,
  input  swo_byte_t                        rx_byte,
  input  logic                             rx_valid,
  input  rule_vec_t                        rule_en,
  input  match_window_t [`MATCH_RULES-1:0] patterns,
  input  match_window_t [`MATCH_RULES-1:0] masks,
  output rule_vec_t                        hits,
  output match_event_t                     match_event,
  output logic                             event_push
);

  match_window_t         window;
  match_window_t         next_window;
  logic [`SEQ_WIDTH-1:0] seq;
  logic [`SEQ_WIDTH-1:0] next_seq;
  rule_vec_t             cmp;

  // compare against the window as it will be once this byte is in
  always_comb begin
    next_window = {window[8*(`MATCH_BYTES-1)-1:0], rx_byte};
    next_seq    = seq + 1'b1;
    for (int r = 0; r < `MATCH_RULES; r++) begin
      cmp[r] = rule_en[r] && (((next_window ^ patterns[r]) & masks[r]) == '0);
    end
  end

  always_ff @(posedge trigger_clk) begin
    if (reset || arm) begin
      window     <= '0;
      seq        <= '0;
      hits       <= '0;
      event_push <= 1'b0;
    end else begin
      hits       <= rx_valid ? cmp : '0;  // one cycle per byte
      event_push <= rx_valid && (|cmp);
      if (rx_valid) begin
        window <= next_window;
        seq    <= next_seq;
      end
    end
  end

  // payload only, qualified by event_push
  always_ff @(posedge trigger_clk) begin
    if (rx_valid) begin
      match_event.hits <= cmp;
      match_event.seq  <= next_seq;
    end
  end

endmodule

`default_nettype wire

/* src/trace_stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "swo_trace_config.svh"

module trace_stream_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     trigger_clk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int DEPTH = `STREAM_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [AW:0]     count;
  logic            do_push;
  logic            do_pop;

  assign full      = (count == (AW+1)'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];  // head stays put until popped
  assign do_push   = push && !full;  // push into a full fifo is lost
  assign do_pop    = out_valid && out_ready;

  always_ff @(posedge trigger_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
    end
  end

  always_ff @(posedge trigger_clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

endmodule

`default_nettype wire

/* src/trace_trigger_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "swo_trace_config.svh"

module trace_trigger_gen
  import swo_trace_pkg::*;
(
  input  logic        trigger_clk,
  input  logic        reset,
  input  logic        arm,
  input  rule_vec_t   hits,
  input  rule_vec_t   trig_en,
  input  trig_count_t num_triggers,
  output logic        trig_out,
  output trig_count_t triggers_generated
);

  localparam int PW = $clog2(`TRIG_PULSE_LEN + 1);

  logic          armed;
  logic [PW-1:0] pulse_cnt;  // cycles left after the current one
  logic          fire;

  // hits during a running pulse are simply ignored
  assign fire = armed && (|(hits & trig_en)) && !trig_out &&
                (triggers_generated < num_triggers);

  always_ff @(posedge trigger_clk) begin
    if (reset) begin
      armed              <= 1'b0;
      triggers_generated <= '0;
      trig_out           <= 1'b0;
      pulse_cnt          <= '0;
    end else begin
      if (arm) begin
        armed              <= 1'b1;
        triggers_generated <= '0;
      end else if (fire) begin
        triggers_generated <= triggers_generated + 1'b1;
      end
      if (fire) begin
        trig_out  <= 1'b1;
        pulse_cnt <= PW'(`TRIG_PULSE_LEN - 1);
      end else if (trig_out) begin
        if (pulse_cnt == '0) trig_out <= 1'b0;
        else pulse_cnt <= pulse_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/swo_trace_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "swo_trace_config.svh"

module swo_trace_top
  import swo_trace_pkg::*;
(
  input  logic                       trigger_clk,
  input  logic                       reset,
  input  logic                       swo,
  input  logic                       cfg_write,
  input  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  logic [`CFG_DATA_WIDTH-1:0] cfg_data,
  output logic                       byte_valid,
  output swo_byte_t                  byte_data,
  input  logic                       byte_ready,
  output logic                       event_valid,
  output match_event_t               event_data,
  input  logic                       event_ready,
  output logic                       trig_out,
  output trig_count_t                triggers_generated,
  output logic                       swo_error
);

  logic                             tick, restart;
  swo_byte_t                        rx_byte;
  logic                             rx_valid, rx_frame_err;
  logic [`SWO_DIV_WIDTH-1:0]        bit_div;
  rule_vec_t                        rule_en, trig_en, hits;
  trig_count_t                      num_triggers;
  match_window_t [`MATCH_RULES-1:0] patterns, masks;
  logic                             arm, clear_errors;
  match_event_t                     match_event;
  logic                             event_push, byte_full, event_full;

  swo_bit_timer u_bit_timer (
    .trigger_clk (trigger_clk), .reset (reset), .restart (restart),
    .bit_div     (bit_div),     .tick  (tick)
  );

  swo_rx_fsm u_rx_fsm (
    .trigger_clk (trigger_clk), .reset    (reset),    .swo          (swo),
    .tick        (tick),        .restart  (restart),  .rx_byte      (rx_byte),
    .rx_valid    (rx_valid),    .rx_frame_err (rx_frame_err)
  );

  match_rule_regs u_regs (
    .trigger_clk (trigger_clk), .reset (reset), .cfg_write (cfg_write),
    .cfg_addr (cfg_addr), .cfg_data (cfg_data), .bit_div (bit_div),
    .rule_en (rule_en), .trig_en (trig_en), .num_triggers (num_triggers),
    .patterns (patterns), .masks (masks), .arm (arm), .clear_errors (clear_errors)
  );

  trace_match_unit u_match (
    .trigger_clk (trigger_clk), .reset (reset), .arm (arm), .rx_byte (rx_byte),
    .rx_valid (rx_valid), .rule_en (rule_en), .patterns (patterns), .masks (masks),
    .hits (hits), .match_event (match_event), .event_push (event_push)
  );

  trace_stream_fifo #(.payload_t(swo_byte_t)) u_byte_fifo (
    .trigger_clk (trigger_clk), .reset (reset), .push (rx_valid), .push_data (rx_byte),
    .full (byte_full), .out_valid (byte_valid), .out_ready (byte_ready),
    .out_data (byte_data)
  );

  trace_stream_fifo #(.payload_t(match_event_t)) u_event_fifo (
    .trigger_clk (trigger_clk), .reset (reset), .push (event_push),
    .push_data (match_event), .full (event_full), .out_valid (event_valid),
    .out_ready (event_ready), .out_data (event_data)
  );

  trace_trigger_gen u_trigger (
    .trigger_clk (trigger_clk), .reset (reset), .arm (arm), .hits (hits),
    .trig_en (trig_en), .num_triggers (num_triggers), .trig_out (trig_out),
    .triggers_generated (triggers_generated)
  );

  // sticky until the host clears it, a new error in the same cycle wins
  always_ff @(posedge trigger_clk) begin
    if (reset) begin
      swo_error <= 1'b0;
    end else if (rx_frame_err || (rx_valid && byte_full) || (event_push && event_full)) begin
      swo_error <= 1'b1;
    end else if (clear_errors) begin
      swo_error <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* dv/swo_trace_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "swo_trace_config.svh"

module swo_trace_asserts
  import swo_trace_pkg::*;
(
  input logic         trigger_clk,
  input logic         reset,
  input logic         trig_out,
  input trig_count_t  triggers_generated,
  input trig_count_t  num_triggers,
  input logic         byte_valid,
  input logic         byte_ready,
  input swo_byte_t    byte_data,
  input logic         event_valid,
  input logic         event_ready,
  input match_event_t event_data
);

  int unsigned high_run;  // cycles trig_out has been high so far

  always_ff @(posedge trigger_clk) begin
    if (reset || !trig_out) high_run <= 0;
    else high_run <= high_run + 1;
  end

  pulse_max_len: assert property (@(posedge trigger_clk) disable iff (reset)
    trig_out |-> high_run < `TRIG_PULSE_LEN)
    else $error("trig_out stayed high longer than the pulse length");

  // falling edge must close a full-length pulse
  pulse_full_len: assert property (@(posedge trigger_clk) disable iff (reset)
    $fell(trig_out) |-> high_run == `TRIG_PULSE_LEN)
    else $error("trig_out pulse ended early");

  byte_stall_stable: assert property (@(posedge trigger_clk) disable iff (reset)
    byte_valid && !byte_ready |=> byte_valid && $stable(byte_data))
    else $error("byte stream changed while stalled");

  event_stall_stable: assert property (@(posedge trigger_clk) disable iff (reset)
    event_valid && !event_ready |=> event_valid && $stable(event_data))
    else $error("event stream changed while stalled");

  trig_count_limit: assert property (@(posedge trigger_clk) disable iff (reset)
    triggers_generated <= num_triggers)
    else $error("triggers_generated ran past num_triggers");

endmodule

`default_nettype wire

/* dv/swo_trace_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "swo_trace_config.svh"

bind swo_trace_top swo_trace_asserts u_asserts (
  .trigger_clk        (trigger_clk),
  .reset              (reset),
  .trig_out           (trig_out),
  .triggers_generated (triggers_generated),
  .num_triggers       (num_triggers),
  .byte_valid         (byte_valid),
  .byte_ready         (byte_ready),
  .byte_data          (byte_data),
  .event_valid        (event_valid),
  .event_ready        (event_ready),
  .event_data         (event_data)
);

module swo_trace_tb
  import swo_trace_pkg::*;
();

  logic                       trigger_clk = 1'b0;
  logic                       reset = 1'b1;
  logic                       swo = 1'b1;  // line idles high
  logic                       cfg_write = 1'b0;
  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr = '0;
  logic [`CFG_DATA_WIDTH-1:0] cfg_data = '0;
  logic                       byte_ready = 1'b0;
  logic                       event_ready = 1'b0;
  logic                       byte_valid, event_valid, trig_out, swo_error;
  swo_byte_t                  byte_data;
  match_event_t               event_data;
  trig_count_t                triggers_generated;

  logic         hold_bytes = 1'b0;
  int           bit_cycles = 1;
  int           send_bits = 0;
  longint       watchdog_ns = 0;
  logic [7:0]   op_q[$];
  logic [31:0]  a_q[$], b_q[$], c_q[$];
  swo_byte_t    byte_q[$];  // bytes still expected on the byte stream
  match_event_t event_q[$];
  swo_byte_t    exp_byte;
  match_event_t exp_event;
  int           trig_pulses = 0;  // rising edges of trig_out so far
  int           pulse_base = 0;   // trig_pulses at the last arm
  logic         trig_out_q = 1'b0;

  swo_trace_top dut (
    .trigger_clk (trigger_clk), .reset (reset), .swo (swo), .cfg_write (cfg_write),
    .cfg_addr (cfg_addr), .cfg_data (cfg_data), .byte_valid (byte_valid),
    .byte_data (byte_data), .byte_ready (byte_ready), .event_valid (event_valid),
    .event_data (event_data), .event_ready (event_ready), .trig_out (trig_out),
    .triggers_generated (triggers_generated), .swo_error (swo_error)
  );

  always #4 trigger_clk = ~trigger_clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    abort_run($sformatf("FAIL at %0t ns: %s got %0h expected %0h", $time, name, got, exp));
  endtask

  task automatic read_input();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] a, b, c;
    fd = $fopen("dv/swo_trace_input.txt", "r");
    assert (fd != 0) else abort_run("cannot open dv/swo_trace_input.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue;
      a = '0;
      b = '0;
      c = 1;
      n = $sscanf(line, "%c %h %h %h", op, a, b, c);
      if (n < 4) c = 1;  // single frame unless a count is given
      op_q.push_back(op);
      a_q.push_back(a);
      b_q.push_back(b);
      c_q.push_back(c);
      if (op == "W" && a == `REG_BIT_DIV) bit_cycles = int'(b) + 1;
      if (op == "S") send_bits += 11 * int'(c);  // start, 8 data, stop, idle
      if (op == "F") send_bits += 11;
    end
    $fclose(fd);
  endtask

  task automatic write_cfg(input logic [`CFG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    if (addr == `REG_CONTROL && data[0]) pulse_base = trig_pulses;  // new arm
    cfg_addr  = addr;
    cfg_data  = data;
    cfg_write = 1'b1;
    @(negedge trigger_clk);
    cfg_write = 1'b0;
    repeat (2) @(negedge trigger_clk);  // control strobes land here
  endtask

  task automatic send_serial(input swo_byte_t data, input logic stop_bit);
    swo = 1'b0;
    repeat (bit_cycles) @(negedge trigger_clk);
    for (int i = 0; i < 8; i++) begin
      swo = data[i];  // lsb first
      repeat (bit_cycles) @(negedge trigger_clk);
    end
    swo = stop_bit;
    repeat (bit_cycles) @(negedge trigger_clk);
    swo = 1'b1;
    repeat (bit_cycles) @(negedge trigger_clk);
  endtask

  task automatic run_step(input logic [7:0] op, input logic [31:0] a, b, c);
    match_event_t evt;
    swo_byte_t    val;
    case (op)
      "W": write_cfg(a[`CFG_ADDR_WIDTH-1:0], b);
      "S": begin
        for (int k = 0; k < int'(c); k++) begin
          val = a[7:0] + 8'(k);
          if (b[0]) byte_q.push_back(val);
          send_serial(val, 1'b1);
        end
      end
      "F": send_serial(a[7:0], 1'b0);
      "E": begin
        evt.hits = a[`MATCH_RULES-1:0];
        evt.seq  = b[`SEQ_WIDTH-1:0];
        event_q.push_back(evt);
      end
      "T": begin
        assert (triggers_generated == a[`TRIG_COUNT_WIDTH-1:0])
          else report_mismatch("triggers_generated", 32'(triggers_generated), a);
        // one pulse on trig_out for every counted trigger
        assert (trig_pulses - pulse_base == int'(a))
          else report_mismatch("trig_out pulses", 32'(trig_pulses - pulse_base), a);
      end
      "X": assert (swo_error == a[0]) else report_mismatch("swo_error", 32'(swo_error), a);
      "H": begin
        while (byte_q.size() != 0) @(negedge trigger_clk);
        hold_bytes = 1'b1;
        @(negedge trigger_clk);
      end
      "R": hold_bytes = 1'b0;
      default: abort_run($sformatf("unknown op %c in the input file", op));
    endcase
  endtask

  // random back-pressure unless the byte side is held off
  always @(negedge trigger_clk) begin
    byte_ready  <= !hold_bytes && ($urandom % 4 != 0);
    event_ready <= ($urandom % 4 != 0);
  end

  always @(posedge trigger_clk) begin
    if (!reset && trig_out && !trig_out_q) trig_pulses++;
    trig_out_q = trig_out;
    if (!reset && byte_valid && byte_ready) begin
      assert (byte_q.size() != 0) else abort_run("byte stream delivered an unexpected byte");
      exp_byte = byte_q.pop_front();
      assert (byte_data == exp_byte)
        else report_mismatch("byte_data", 32'(byte_data), 32'(exp_byte));
    end
    if (!reset && event_valid && event_ready) begin
      assert (event_q.size() != 0) else abort_run("event stream delivered an unexpected event");
      exp_event = event_q.pop_front();
      assert (event_data == exp_event)
        else report_mismatch("event_data", 32'(event_data), 32'(exp_event));
    end
  end

  initial begin
    wait (watchdog_ns != 0);
    #(watchdog_ns);
    abort_run($sformatf("timeout, run still busy after %0d ns", watchdog_ns));
  end

  initial begin
    void'($urandom(11));
    read_input();
    watchdog_ns = longint'(send_bits) * bit_cycles * 16 + 20000;  // twice the bit time
    repeat (16) @(posedge trigger_clk);
    @(negedge trigger_clk);
    reset = 1'b0;
    @(negedge trigger_clk);
    assert (!byte_valid && !event_valid && !trig_out && !swo_error && triggers_generated == 0)
      else abort_run("outputs are not idle after reset");
    for (int i = 0; i < op_q.size(); i++) run_step(op_q[i], a_q[i], b_q[i], c_q[i]);
    while (byte_q.size() != 0 || event_q.size() != 0) @(negedge trigger_clk);
    repeat (8) @(negedge trigger_clk);
    assert (!byte_valid && !event_valid) else abort_run("a stream holds an item nobody expected");
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
src/swo_trace_pkg.sv
src/swo_bit_timer.sv
src/swo_rx_fsm.sv
src/match_rule_regs.sv
src/trace_match_unit.sv
src/trace_stream_fifo.sv
src/trace_trigger_gen.sv
src/swo_trace_top.sv
dv/swo_trace_asserts.sv
dv/swo_trace_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the swo trace testbench with verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f tb.f --top-module swo_trace_tb -o swo_trace_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/swo_trace_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "Some tests failed" "$log"; then
  echo "simulation reported a failure, see $log"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
echo "simulation finished cleanly"
exit 0

/* dv/swo_trace_input.txt */
# op a b c in hex: W addr data | S byte expect count | F byte with low stop bit
# E hits seq | T triggers_generated | X swo_error | H hold byte_ready | R release it
W 0 7
W 4 41424344
W 8 ffffffff
W 5 55
W 9 ff
W 6 44
W a ff
W 2 2
W 1 23
W 3 1
S 41 1
S 42 1
S 43 1
E 1 4
S 44 1
E 2 5
S 55 1
T 1
E 2 6
S 55 1
T 2
E 2 7
S 55 1
T 2
W 3 1
T 0
E 2 1
S 55 1
T 1
F 55
X 1
T 1
W 3 2
X 0
S 56 1
W 1 0
H
S 10 1 8
S 18 0 2
X 1
R
